//--- Makefile
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/ooo_core_chk.sv
`timescale 1ns/1ps

module ooo_core_chk import ooo_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  in_ready,
    input logic  commit_valid,
    input logic  commit_ready,
    input areg_t commit_rd,
    input word_t commit_value
);

    int fail_count = 0;     // polled by the testbench

    // a waiting commit keeps valid and payload
    commit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=>
            commit_valid && $stable(commit_rd) && $stable(commit_value))
    else begin
        $error("commit port changed while waiting for commit_ready");
        fail_count++;
    end

    commit_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !commit_valid)
    else begin
        $error("commit_valid high in the cycle after reset");
        fail_count++;
    end

    ready_after_reset: assert property (@(posedge clk) !rst_n |=> in_ready)
    else begin
        $error("in_ready low right after reset");
        fail_count++;
    end

endmodule

//--- test/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb import ooo_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int N_INDEP      = 24;
    localparam int N_CHAIN      = 12;
    localparam int N_BACKP      = 33;   // 9 around the stall, 24 under random ready
    localparam int N_ZERO       = 6;
    localparam int N_RAND       = 200;
    localparam int N_INSTR      = N_INDEP + N_CHAIN + N_BACKP + N_ZERO + N_RAND;
    localparam int CYCLE_LIMIT  = 20 * N_INSTR + RESET_CYCLES;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    in_valid;
    logic    in_ready;
    opcode_t in_op;
    areg_t   in_rd, in_rs1, in_rs2;
    word_t   in_imm;
    logic    in_use_imm;
    logic    commit_valid;
    logic    commit_ready = 1'b1;
    areg_t   commit_rd;
    word_t   commit_value;

    word_t shadow [ARCH_REGS];      // sequential register state
    areg_t exp_rd [$];
    word_t exp_val [$];
    int    accepted_cnt  = 0;
    int    committed_cnt = 0;
    int    cycle_cnt     = 0;
    int    ready_mode    = 0;       // 0 ready, 1 random, 2 stalled

    ooo_core UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_op        (in_op),
        .in_rd        (in_rd),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_imm       (in_imm),
        .in_use_imm   (in_use_imm),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    bind ooo_core ooo_core_chk u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_ready     (in_ready),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    always #5 clk = ~clk;

    function automatic word_t expected_result(input opcode_t op, input word_t a, input word_t b);
        logic [4:0] sh;
        word_t      r;
        sh = b[4:0];
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a + ~b + 1;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << sh;
            OP_SRL:  r = a >> sh;
            OP_SRA:  r = (a >> sh) | (a[XLEN-1] ? ~(32'hffff_ffff >> sh) : '0);
            // signs differ means the negative one is smaller
            OP_SLT:  r = (a[XLEN-1] != b[XLEN-1]) ? word_t'(a[XLEN-1]) : word_t'(a < b);
            OP_SLTU: r = word_t'(a < b);
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic drive(input opcode_t op, input areg_t rd, input areg_t rs1, input areg_t rs2,
                         input word_t imm, input logic use_imm);
        in_valid   <= 1'b1;
        in_op      <= op;
        in_rd      <= rd;
        in_rs1     <= rs1;
        in_rs2     <= rs2;
        in_imm     <= imm;
        in_use_imm <= use_imm;
    endtask

    task automatic wait_accept();
        do @(posedge clk); while (!in_ready);
    endtask

    task automatic send(input opcode_t op, input areg_t rd, input areg_t rs1, input areg_t rs2,
                        input word_t imm, input logic use_imm);
        drive(op, rd, rs1, rs2, imm, use_imm);
        wait_accept();
    endtask

    task automatic drive_random(input int max_reg);
        drive(opcode_t'($urandom_range(9, 0)), areg_t'($urandom_range(max_reg, 0)),
              areg_t'($urandom_range(max_reg, 0)), areg_t'($urandom_range(max_reg, 0)),
              $urandom, 1'($urandom_range(1, 0)));
    endtask

    task automatic idle(input int n);
        in_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_drain();
        in_valid <= 1'b0;
        do @(posedge clk); while (committed_cnt != accepted_cnt);
    endtask

    task automatic run_independent();
        send(OP_ADD, 5'd1, 5'd0, 5'd0, 32'h8000_1234, 1'b1);
        send(OP_ADD, 5'd2, 5'd0, 5'd0, 32'h0000_0013, 1'b1);
        send(OP_ADD, 5'd3, 5'd0, 5'd0, 32'h7fff_fff0, 1'b1);
        send(OP_ADD, 5'd4, 5'd0, 5'd0, 32'hffff_ff85, 1'b1);
        for (int op = 0; op <= OP_SLTU; op++)
            send(opcode_t'(op), areg_t'(10 + op), areg_t'(1 + op % 4),
                 areg_t'(1 + (op + 1) % 4), '0, 1'b0);
        for (int op = 0; op <= OP_SLTU; op++)
            send(opcode_t'(op), areg_t'(20 + op), areg_t'(1 + (op + 2) % 4), 5'd0, $urandom, 1'b1);
    endtask

    // x5 and x6 feed each other, x5 rewritten back to back
    task automatic run_chains();
        areg_t dst;
        send(OP_ADD, 5'd5, 5'd0, 5'd0, 32'd7, 1'b1);
        send(OP_SUB, 5'd6, 5'd0, 5'd5, '0, 1'b0);
        for (int i = 0; i < N_CHAIN - 2; i++) begin
            dst = (i % 3 == 2) ? areg_t'(6) : areg_t'(5);
            send(opcode_t'($urandom_range(9, 0)), dst, 5'd5, 5'd6,
                 word_t'($urandom_range(31, 0)), i[0]);
        end
    endtask

    task automatic run_backpressure();
        int taken;
        taken = 0;
        wait_drain();
        ready_mode <= 2;
        repeat (2) @(posedge clk);
        drive_random(7);
        repeat (40) begin
            @(posedge clk);
            if (in_ready) begin
                taken++;
                drive_random(7);
            end
        end
        assert (taken <= ROB_DEPTH && !in_ready)
        else stop_on_error($sformatf("in_ready still high after %0d accepts with commit stalled",
                                     taken));
        ready_mode <= 1;
        wait_accept();          // the held instruction goes in
        repeat (N_BACKP - ROB_DEPTH - 1) begin
            drive_random(7);
            wait_accept();
        end
    endtask

    task automatic run_zero_reg();
        send(OP_ADD,  5'd0,  5'd1, 5'd0, 32'h55, 1'b1);  // dropped write
        send(OP_ADD,  5'd7,  5'd0, 5'd0, '0, 1'b0);
        send(OP_OR,   5'd0,  5'd2, 5'd3, '0, 1'b0);
        send(OP_SUB,  5'd8,  5'd0, 5'd1, '0, 1'b0);
        send(OP_XOR,  5'd9,  5'd0, 5'd0, 32'h0f0f_0f0f, 1'b1);
        send(OP_SLTU, 5'd10, 5'd0, 5'd0, '0, 1'b0);
    endtask

    task automatic run_random();
        ready_mode <= 1;
        for (int i = 0; i < N_RAND; i++) begin
            if ($urandom_range(3, 0) == 0)
                idle($urandom_range(3, 1));
            drive_random(7);
            wait_accept();
        end
    endtask

    always @(posedge clk) begin
        case (ready_mode)
            0:       commit_ready <= 1'b1;
            1:       commit_ready <= ($urandom_range(3, 0) != 0);
            default: commit_ready <= 1'b0;
        endcase
    end

    // reference model, fed in acceptance order
    always @(posedge clk) begin
        word_t a, b, v;
        if (!rst_n) begin
            for (int r = 0; r < ARCH_REGS; r++)
                shadow[r] = '0;
        end else if (in_valid && in_ready) begin
            a = shadow[in_rs1];
            b = in_use_imm ? in_imm : shadow[in_rs2];
            v = expected_result(in_op, a, b);
            exp_rd.push_back(in_rd);
            exp_val.push_back(v);
            if (in_rd != '0)
                shadow[in_rd] = v;
            accepted_cnt++;
        end
    end

    // handshake seen half a cycle before its edge
    always @(negedge clk) begin
        areg_t want_rd;
        word_t want_val;
        if (rst_n && commit_valid && commit_ready) begin
            assert (exp_val.size() > 0)
            else stop_on_error("commit handshake with no instruction outstanding");
            want_rd  = exp_rd.pop_front();
            want_val = exp_val.pop_front();
            assert (commit_rd == want_rd && commit_value == want_val)
            else stop_on_error($sformatf(
                "FAILED at %0t: commit %0d gave x%0d = 0x%08h, expected x%0d = 0x%08h",
                $time, committed_cnt, commit_rd, commit_value, want_rd, want_val));
            committed_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT)
            stop_on_error($sformatf("timed out after %0d cycles with %0d of %0d commits",
                                    cycle_cnt, committed_cnt, N_INSTR));
        else if (UUT.u_chk.fail_count != 0)
            stop_on_error("a protocol assertion on the commit port failed");
    end

    initial begin
        void'($urandom(32'h7d6b_30c1));
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_op      = OP_ADD;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_imm     = '0;
        in_use_imm = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        run_independent();
        run_chains();
        run_backpressure();
        ready_mode <= 0;
        run_zero_reg();
        run_random();
        wait_drain();
        repeat (4) @(posedge clk);      // room for a stray extra commit
        if (exp_val.size() == 0 && committed_cnt == N_INSTR) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_on_error($sformatf("run ended with %0d of %0d instructions committed",
                                    committed_cnt, N_INSTR));
        end
    end

endmodule

//--- verilog/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    iss_valid,
    input  opcode_t iss_op,
    input  tag_t    iss_tag,
    input  word_t   iss_a,
    input  word_t   iss_b,
    output logic    res_valid,
    output tag_t    res_tag,
    output word_t   res_value
);

    logic [ALU_STAGES-1:0] vld_q;
    tag_t                  tag_q [ALU_STAGES];
    word_t                 val_q [ALU_STAGES];
    word_t                 result;

    always_comb begin
        case (iss_op)
            OP_ADD:  result = iss_a + iss_b;
            OP_SUB:  result = iss_a - iss_b;
            OP_AND:  result = iss_a & iss_b;
            OP_OR:   result = iss_a | iss_b;
            OP_XOR:  result = iss_a ^ iss_b;
            OP_SLL:  result = iss_a << iss_b[4:0];
            OP_SRL:  result = iss_a >> iss_b[4:0];
            OP_SRA:  result = word_t'($signed(iss_a) >>> iss_b[4:0]);
            OP_SLT:  result = word_t'($signed(iss_a) < $signed(iss_b));
            OP_SLTU: result = word_t'(iss_a < iss_b);
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            vld_q <= '0;
        else
            vld_q <= {vld_q[ALU_STAGES-2:0], iss_valid};
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= iss_tag;
        val_q[0] <= result;
        for (int s = 1; s < ALU_STAGES; s++) begin
            tag_q[s] <= tag_q[s-1];
            val_q[s] <= val_q[s-1];
        end
    end

    assign res_valid = vld_q[ALU_STAGES-1];
    assign res_tag   = tag_q[ALU_STAGES-1];
    assign res_value = val_q[ALU_STAGES-1];

endmodule

//--- verilog/dispatch_if.sv
`timescale 1ns/1ps

interface dispatch_if import ooo_pkg::*; ();

    logic    fire;        // instruction accepted this cycle
    tag_t    tag;
    opcode_t op;
    areg_t   rd;
    word_t   src1_value;
    tag_t    src1_tag;
    logic    src1_ready;
    word_t   src2_value;
    tag_t    src2_tag;
    logic    src2_ready;

    logic    iq_ready;
    logic    rob_ready;
    tag_t    alloc_tag;   // next free rob slot

    modport rename (
        output fire, tag, op, rd,
        output src1_value, src1_tag, src1_ready,
        output src2_value, src2_tag, src2_ready,
        input  iq_ready, rob_ready, alloc_tag
    );

    modport queue (
        input  fire, tag, op,
        input  src1_value, src1_tag, src1_ready,
        input  src2_value, src2_tag, src2_ready,
        output iq_ready
    );

    modport rob (
        input  fire, rd,
        output rob_ready, alloc_tag
    );

endinterface

//--- verilog/issue_queue.sv
`timescale 1ns/1ps

module issue_queue import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    res_valid,
    input  tag_t    res_tag,
    input  word_t   res_value,
    dispatch_if.queue disp,
    output logic    iss_valid,
    output opcode_t iss_op,
    output tag_t    iss_tag,
    output word_t   iss_a,
    output word_t   iss_b
);

    logic [IQ_DEPTH-1:0] vld;
    logic [IQ_DEPTH-1:0] a_rdy, b_rdy;
    opcode_t             op_q  [IQ_DEPTH];
    tag_t                tag_q [IQ_DEPTH];
    tag_t                a_tag [IQ_DEPTH];
    tag_t                b_tag [IQ_DEPTH];
    word_t               a_val [IQ_DEPTH];
    word_t               b_val [IQ_DEPTH];
    logic [IQ_DEPTH-1:0] older [IQ_DEPTH];  // older[i][j] set when i came before j

    logic [IQ_DEPTH-1:0] rdy;
    logic [IQ_IDX_W-1:0] free_idx, sel_idx;

    assign rdy           = vld & a_rdy & b_rdy;
    assign disp.iq_ready = ~&vld;

    // lowest free entry
    always_comb begin
        free_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--)
            if (!vld[i])
                free_idx = IQ_IDX_W'(i);
    end

    // oldest ready entry
    always_comb begin
        logic blocked;
        iss_valid = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            blocked = 1'b0;
            for (int j = 0; j < IQ_DEPTH; j++)
                if (j != i && rdy[j] && older[j][i])
                    blocked = 1'b1;
            if (rdy[i] && !blocked) begin
                iss_valid = 1'b1;
                sel_idx   = IQ_IDX_W'(i);
            end
        end
    end

    assign iss_op  = op_q[sel_idx];
    assign iss_tag = tag_q[sel_idx];
    assign iss_a   = a_val[sel_idx];
    assign iss_b   = b_val[sel_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            if (iss_valid)
                vld[sel_idx] <= 1'b0;
            if (disp.fire)
                vld[free_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (res_valid && !a_rdy[i] && a_tag[i] == res_tag) begin
                a_val[i] <= res_value;
                a_rdy[i] <= 1'b1;
            end
            if (res_valid && !b_rdy[i] && b_tag[i] == res_tag) begin
                b_val[i] <= res_value;
                b_rdy[i] <= 1'b1;
            end
        end
        if (disp.fire) begin
            op_q[free_idx]  <= disp.op;
            tag_q[free_idx] <= disp.tag;
            a_val[free_idx] <= disp.src1_value;
            a_tag[free_idx] <= disp.src1_tag;
            a_rdy[free_idx] <= disp.src1_ready;
            b_val[free_idx] <= disp.src2_value;
            b_tag[free_idx] <= disp.src2_tag;
            b_rdy[free_idx] <= disp.src2_ready;
            for (int j = 0; j < IQ_DEPTH; j++) begin
                older[j][free_idx] <= 1'b1;   // everyone present is older
                older[free_idx][j] <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/ooo_core.sv
`timescale 1ns/1ps

module ooo_core import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    in_valid,
    output logic    in_ready,
    input  opcode_t in_op,
    input  areg_t   in_rd,
    input  areg_t   in_rs1,
    input  areg_t   in_rs2,
    input  word_t   in_imm,
    input  logic    in_use_imm,

    output logic    commit_valid,
    input  logic    commit_ready,
    output areg_t   commit_rd,
    output word_t   commit_value
);

    dispatch_if disp ();
    retire_if   ret ();

    // result bus
    logic  res_valid;
    tag_t  res_tag;
    word_t res_value;

    // issue to alu
    logic    iss_valid;
    opcode_t iss_op;
    tag_t    iss_tag;
    word_t   iss_a, iss_b;

    rename_stage u_rename (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_rd      (in_rd),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_imm     (in_imm),
        .in_use_imm (in_use_imm),
        .res_valid  (res_valid),
        .res_tag    (res_tag),
        .res_value  (res_value),
        .disp       (disp.rename),
        .ret        (ret.rename)
    );

    issue_queue u_iq (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_value (res_value),
        .disp      (disp.queue),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .iss_tag   (iss_tag),
        .iss_a     (iss_a),
        .iss_b     (iss_b)
    );

    alu_unit u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (iss_valid),
        .iss_op    (iss_op),
        .iss_tag   (iss_tag),
        .iss_a     (iss_a),
        .iss_b     (iss_b),
        .res_valid (res_valid),
        .res_tag   (res_tag),
        .res_value (res_value)
    );

    reorder_buffer u_rob (
        .clk          (clk),
        .rst_n        (rst_n),
        .res_valid    (res_valid),
        .res_tag      (res_tag),
        .res_value    (res_value),
        .disp         (disp.rob),
        .ret          (ret.rob),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

endmodule

//--- verilog/ooo_pkg.sv
package ooo_pkg;

    // core sizing
    localparam int XLEN       = 32;
    localparam int ARCH_REGS  = 32;
    localparam int ROB_DEPTH  = 8;  // also the number of tags
    localparam int IQ_DEPTH   = 4;
    localparam int ALU_STAGES = 2;

    localparam int AREG_W   = $clog2(ARCH_REGS);
    localparam int TAG_W    = $clog2(ROB_DEPTH);
    localparam int IQ_IDX_W = $clog2(IQ_DEPTH);
    localparam int CNT_W    = $clog2(ROB_DEPTH + 1);

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [TAG_W-1:0]  tag_t;   // rob slot index
    typedef logic [3:0]        opcode_t;

    // alu operations
    localparam opcode_t OP_ADD  = 4'd0;
    localparam opcode_t OP_SUB  = 4'd1;
    localparam opcode_t OP_AND  = 4'd2;
    localparam opcode_t OP_OR   = 4'd3;
    localparam opcode_t OP_XOR  = 4'd4;
    localparam opcode_t OP_SLL  = 4'd5;
    localparam opcode_t OP_SRL  = 4'd6;
    localparam opcode_t OP_SRA  = 4'd7;
    localparam opcode_t OP_SLT  = 4'd8;
    localparam opcode_t OP_SLTU = 4'd9;

endpackage

//--- verilog/rename_stage.sv
`timescale 1ns/1ps

module rename_stage import ooo_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    output logic    in_ready,
    input  opcode_t in_op,
    input  areg_t   in_rd,
    input  areg_t   in_rs1,
    input  areg_t   in_rs2,
    input  word_t   in_imm,
    input  logic    in_use_imm,
    input  logic    res_valid,
    input  tag_t    res_tag,
    input  word_t   res_value,
    dispatch_if.rename disp,
    retire_if.rename   ret
);

    logic [ARCH_REGS-1:0] rat_busy;
    tag_t                 rat_tag [ARCH_REGS];
    word_t                arch_rf [ARCH_REGS];
    word_t                val_file [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] val_ok;     // tag has produced its value

    word_t s1_value, s2_value;
    tag_t  s1_tag, s2_tag;
    logic  s1_ready, s2_ready;

    function automatic void lookup(input areg_t r, output word_t v, output tag_t t,
                                   output logic rdy);
        t   = rat_tag[r];
        v   = '0;
        rdy = 1'b1;
        if (r == '0)
            v = '0;
        else if (!rat_busy[r])
            v = arch_rf[r];
        else if (val_ok[t])
            v = val_file[t];
        else if (res_valid && res_tag == t)
            v = res_value;              // bypass from the result bus
        else
            rdy = 1'b0;
    endfunction

    always_comb begin
        lookup(in_rs1, s1_value, s1_tag, s1_ready);
        lookup(in_rs2, s2_value, s2_tag, s2_ready);
    end

    assign in_ready        = disp.iq_ready & disp.rob_ready;
    assign disp.fire       = in_valid & in_ready;
    assign disp.tag        = disp.alloc_tag;
    assign disp.op         = in_op;
    assign disp.rd         = in_rd;
    assign disp.src1_value = s1_value;
    assign disp.src1_tag   = s1_tag;
    assign disp.src1_ready = s1_ready;
    // immediate replaces rs2
    assign disp.src2_value = in_use_imm ? in_imm : s2_value;
    assign disp.src2_tag   = in_use_imm ? tag_t'(0) : s2_tag;
    assign disp.src2_ready = in_use_imm | s2_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rat_busy <= '0;
            val_ok   <= '0;
            for (int i = 0; i < ARCH_REGS; i++)
                arch_rf[i] <= '0;
        end else begin
            if (res_valid)
                val_ok[res_tag] <= 1'b1;
            if (disp.fire)
                val_ok[disp.alloc_tag] <= 1'b0;
            if (ret.en) begin
                if (ret.rd != '0)
                    arch_rf[ret.rd] <= ret.value;
                if (rat_tag[ret.rd] == ret.tag)
                    rat_busy[ret.rd] <= 1'b0;
            end
            // a rename of the same register this cycle keeps it busy
            if (disp.fire && in_rd != '0)
                rat_busy[in_rd] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid)
            val_file[res_tag] <= res_value;
        if (disp.fire && in_rd != '0)
            rat_tag[in_rd] <= disp.alloc_tag;
    end

endmodule

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer import ooo_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  res_valid,
    input  tag_t  res_tag,
    input  word_t res_value,
    dispatch_if.rob disp,
    retire_if.rob   ret,
    output logic  commit_valid,
    input  logic  commit_ready,
    output areg_t commit_rd,
    output word_t commit_value
);

    areg_t                rd_q  [ROB_DEPTH];
    word_t                val_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;

    tag_t             head, tail;   // wrap on their own, depth is a power of two
    logic [CNT_W-1:0] count;
    logic             push, pop;

    assign push = disp.fire;
    assign pop  = commit_valid & commit_ready;

    assign disp.alloc_tag = tail;
    assign disp.rob_ready = count < CNT_W'(ROB_DEPTH);

    // head goes out only once its result is back
    assign commit_valid = (count != '0) && done_q[head];
    assign commit_rd    = rd_q[head];
    assign commit_value = val_q[head];

    assign ret.en    = pop;
    assign ret.rd    = rd_q[head];
    assign ret.tag   = head;
    assign ret.value = val_q[head];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push)
                tail <= tail + 1'b1;
            if (pop)
                head <= head + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= '0;
        end else begin
            if (res_valid)
                done_q[res_tag] <= 1'b1;
            if (push)
                done_q[tail] <= 1'b0;   // fresh slot waits for the alu
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid)
            val_q[res_tag] <= res_value;
        if (push)
            rd_q[tail] <= disp.rd;
    end

endmodule

//--- verilog/retire_if.sv
`timescale 1ns/1ps

interface retire_if import ooo_pkg::*; ();

    logic  en;      // commit handshake
    areg_t rd;
    tag_t  tag;
    word_t value;

    modport rob (
        output en, rd, tag, value
    );

    modport rename (
        input  en, rd, tag, value
    );

endinterface

//--- vlog.f
verilog/ooo_pkg.sv
verilog/dispatch_if.sv
verilog/retire_if.sv
verilog/rename_stage.sv
verilog/issue_queue.sv
verilog/alu_unit.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
test/ooo_core_chk.sv
test/ooo_core_tb.sv
